// ==== source/stream_buf_pkg.sv ====
// shared sizes and types; NumWords must be a power of two and 2*CntWidth must equal DataWidth
package stream_buf_pkg;

  // buffer depth in words
  localparam int unsigned NumWords = 16;
  // width of one stream word
  localparam int unsigned DataWidth = 32;
  // sram address width, log2 of NumWords
  localparam int unsigned AddrWidth = 4;
  // fill level, one bit wider than the address to hold NumWords
  localparam int unsigned LengthWidth = 5;
  // each saturating drop counter
  localparam int unsigned CntWidth = 16;

  // register map of the configuration port
  typedef enum logic [1:0] {
    // bit 0 enables the buffer
    CFG_CTRL      = 2'd0,
    // level threshold for the interrupt
    CFG_WATERMARK = 2'd1,
    // current fill level, read only
    CFG_LEVEL     = 2'd2,
    // push drops in the upper half, pop drops in the lower half, read only
    CFG_DROPS     = 2'd3
  } cfg_addr_e;

  // one-cycle configuration request
  typedef struct packed {
    logic                 valid;
    logic                 write;
    cfg_addr_e            addr;
    logic [DataWidth-1:0] wdata;
  } cfg_req_t;

  // single word push strobe with its data
  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] data;
  } push_req_t;

  // drop strobes raised by the guard
  typedef struct packed {
    logic push_drop;
    logic pop_drop;
  } drop_t;

  // fill status of the shift register
  typedef struct packed {
    logic                   empty;
    logic                   full;
    logic [LengthWidth-1:0] level;
  } buf_status_t;

endpackage

// ==== source/sram_sp.sv ====
// single-port sram model with one cycle read latency; array and read register are not reset
`timescale 1ns/1ps

module sram_sp #(
  parameter int unsigned NumWords  = 16,
  parameter int unsigned DataWidth = 32
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  logic [DataWidth-1:0]        wdata_i,
  output logic [DataWidth-1:0]        rdata_o
);

  // storage array, contents undefined until written
  logic [DataWidth-1:0] mem_q [NumWords];
  // read data register
  logic [DataWidth-1:0] rdata_q;

  // a write does not update the read register
  // a read request in cycle N shows its word in cycle N+1
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  // read register holds its value while idle
  assign rdata_o = rdata_q;

endmodule

// ==== source/sram_shift_reg.sv ====
// sram backed FIFO; requests must be legal (no push when full, no pop when empty or busy)
`timescale 1ns/1ps

module sram_shift_reg (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  stream_buf_pkg::push_req_t              push_i,
  input  logic                                   pop_i,
  output logic [stream_buf_pkg::DataWidth-1:0]   front_data_o,
  output stream_buf_pkg::buf_status_t            status_o,
  output logic                                   pop_busy_o
);

  // next free slot
  logic [stream_buf_pkg::AddrWidth-1:0]   back_addr_q;
  // number of stored words
  logic [stream_buf_pkg::LengthWidth-1:0] length_q;
  // pop that lost the sram to a push and still waits for its read
  logic                                   pop_pend_q;
  // address of the oldest word
  logic [stream_buf_pkg::AddrWidth-1:0]   front_addr;
  logic                                   empty;
  logic                                   full;
  // sram request side
  logic                                   sram_req;
  logic [stream_buf_pkg::AddrWidth-1:0]   sram_addr;

  // front sits length words behind the back, wraps with the address width
  assign front_addr = back_addr_q - length_q[stream_buf_pkg::AddrWidth-1:0];

  assign empty = (length_q == '0);
  assign full  = (length_q == stream_buf_pkg::LengthWidth'(stream_buf_pkg::NumWords));

  // length counts a pop when it is accepted, even if its read is deferred
  // so the derived front address is already right for the deferred read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      back_addr_q <= '0;
      length_q    <= '0;
      pop_pend_q  <= 1'b0;
    end else begin
      if (push_i.valid) begin
        back_addr_q <= back_addr_q + 1'b1;
      end
      if (push_i.valid && !pop_i) begin
        length_q <= length_q + 1'b1;
      end else if (!push_i.valid && pop_i) begin
        length_q <= length_q - 1'b1;
      end
      // a push owns the port, so the front read slips while pushes keep coming
      pop_pend_q <= (pop_i | pop_pend_q) & push_i.valid;
    end
  end

  // idle cycles keep re-reading the front so the word stays visible
  // no request at all while empty, nothing valid to show
  assign sram_req = push_i.valid | ~empty;

  // push writes the back slot
  // a plain pop reads the word after the current front
  // otherwise refresh the front
  always_comb begin
    if (push_i.valid) begin
      sram_addr = back_addr_q;
    end else if (pop_i) begin
      sram_addr = front_addr + 1'b1;
    end else begin
      sram_addr = front_addr;
    end
  end

  sram_sp #(
    .NumWords  (stream_buf_pkg::NumWords),
    .DataWidth (stream_buf_pkg::DataWidth)
  ) u_sram_sp (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (push_i.valid),
    .addr_i  (sram_addr),
    .wdata_i (push_i.data),
    .rdata_o (front_data_o)
  );

  assign status_o.empty = empty;
  assign status_o.full  = full;
  assign status_o.level = length_q;
  assign pop_busy_o     = pop_pend_q;

endmodule

// ==== source/buffer_guard.sv ====
// combinational request filter; status and pop_busy must come from the shift register it guards
`timescale 1ns/1ps

module buffer_guard (
  input  stream_buf_pkg::push_req_t   wr_i,
  input  logic                        rd_i,
  input  logic                        enable_i,
  input  stream_buf_pkg::buf_status_t status_i,
  input  logic                        pop_busy_i,
  output stream_buf_pkg::push_req_t   push_o,
  output logic                        pop_o,
  output stream_buf_pkg::drop_t       drop_o
);

  logic push_ok;
  logic pop_ok;

  // push needs the block enabled and room left
  assign push_ok = wr_i.valid & enable_i & ~status_i.full;

  // pop needs a word and no earlier pop still waiting on the sram
  // enable does not gate pops so a disabled buffer can still drain
  assign pop_ok = rd_i & ~status_i.empty & ~pop_busy_i;

  // accepted push passes on, data goes through untouched
  assign push_o.valid = push_ok;
  assign push_o.data  = wr_i.data;

  assign pop_o = pop_ok;

  // every rejected strobe becomes a one-cycle drop pulse
  assign drop_o.push_drop = wr_i.valid & ~push_ok;
  assign drop_o.pop_drop  = rd_i & ~pop_ok;

endmodule

// ==== source/buffer_regs.sv ====
// config and status registers; reads return data one cycle later, read-only writes are ignored
`timescale 1ns/1ps

module buffer_regs (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  stream_buf_pkg::cfg_req_t             cfg_i,
  output logic [stream_buf_pkg::DataWidth-1:0] cfg_rdata_o,
  input  stream_buf_pkg::buf_status_t          status_i,
  input  stream_buf_pkg::drop_t                drop_i,
  output logic                                 enable_o,
  output logic                                 level_irq_o
);

  // control and threshold
  logic                                   enable_q;
  logic [stream_buf_pkg::LengthWidth-1:0] watermark_q;
  // saturating drop counters
  logic [stream_buf_pkg::CntWidth-1:0]    push_cnt_q;
  logic [stream_buf_pkg::CntWidth-1:0]    pop_cnt_q;
  // registered read data and interrupt
  logic [stream_buf_pkg::DataWidth-1:0]   rdata_q;
  logic [stream_buf_pkg::DataWidth-1:0]   rdata_d;
  logic                                   irq_q;
  logic                                   cfg_wr;
  logic                                   cfg_rd;

  assign cfg_wr = cfg_i.valid & cfg_i.write;
  assign cfg_rd = cfg_i.valid & ~cfg_i.write;

  // writable registers, new value visible the cycle after the request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q    <= 1'b0;
      watermark_q <= '0;
    end else if (cfg_wr) begin
      case (cfg_i.addr)
        stream_buf_pkg::CFG_CTRL: begin
          enable_q <= cfg_i.wdata[0];
        end
        stream_buf_pkg::CFG_WATERMARK: begin
          watermark_q <= cfg_i.wdata[stream_buf_pkg::LengthWidth-1:0];
        end
        // level and drops are read only
        default: begin
        end
      endcase
    end
  end

  // drop counters stick at all ones
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      push_cnt_q <= '0;
      pop_cnt_q  <= '0;
    end else begin
      if (drop_i.push_drop && (push_cnt_q != '1)) begin
        push_cnt_q <= push_cnt_q + 1'b1;
      end
      if (drop_i.pop_drop && (pop_cnt_q != '1)) begin
        pop_cnt_q <= pop_cnt_q + 1'b1;
      end
    end
  end

  // read mux, unused upper bits read as zero
  always_comb begin
    rdata_d = '0;
    case (cfg_i.addr)
      stream_buf_pkg::CFG_CTRL:      rdata_d[0] = enable_q;
      stream_buf_pkg::CFG_WATERMARK: rdata_d[stream_buf_pkg::LengthWidth-1:0] = watermark_q;
      stream_buf_pkg::CFG_LEVEL:     rdata_d[stream_buf_pkg::LengthWidth-1:0] = status_i.level;
      default:                       rdata_d = {push_cnt_q, pop_cnt_q};
    endcase
  end

  // read data holds until the next read request
  // irq follows the level against the threshold, one cycle late
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      if (cfg_rd) begin
        rdata_q <= rdata_d;
      end
      irq_q <= enable_q & (status_i.level >= watermark_q);
    end
  end

  assign cfg_rdata_o = rdata_q;
  assign enable_o    = enable_q;
  assign level_irq_o = irq_q;

endmodule

// ==== source/stream_buf_top.sv ====
// stream buffer top; no back-pressure, producer watches full_o and drops are only counted
`timescale 1ns/1ps

module stream_buf_top (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  stream_buf_pkg::push_req_t            wr_i,
  input  logic                                 rd_i,
  output logic [stream_buf_pkg::DataWidth-1:0] rd_data_o,
  input  stream_buf_pkg::cfg_req_t             cfg_i,
  output logic [stream_buf_pkg::DataWidth-1:0] cfg_rdata_o,
  output logic                                 empty_o,
  output logic                                 full_o,
  output logic                                 level_irq_o
);

  // accepted requests from the guard
  stream_buf_pkg::push_req_t   push_acc;
  logic                        pop_acc;
  stream_buf_pkg::drop_t       drops;
  // shift register state seen by guard and registers
  stream_buf_pkg::buf_status_t status;
  logic                        pop_busy;
  logic                        enable;

  buffer_guard u_buffer_guard (
    .wr_i       (wr_i),
    .rd_i       (rd_i),
    .enable_i   (enable),
    .status_i   (status),
    .pop_busy_i (pop_busy),
    .push_o     (push_acc),
    .pop_o      (pop_acc),
    .drop_o     (drops)
  );

  buffer_regs u_buffer_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg_i),
    .cfg_rdata_o (cfg_rdata_o),
    .status_i    (status),
    .drop_i      (drops),
    .enable_o    (enable),
    .level_irq_o (level_irq_o)
  );

  sram_shift_reg u_sram_shift_reg (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (push_acc),
    .pop_i        (pop_acc),
    .front_data_o (rd_data_o),
    .status_o     (status),
    .pop_busy_o   (pop_busy)
  );

  // flags straight from the shift register
  assign empty_o = status.empty;
  assign full_o  = status.full;

endmodule

// ==== tests/stream_buf_properties.sv ====
// concurrent checks on the nets between guard and shift register; inactive while in reset
`timescale 1ns/1ps

module stream_buf_properties (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  stream_buf_pkg::push_req_t   push_i,
  input  logic                        pop_i,
  input  stream_buf_pkg::buf_status_t status_i,
  input  logic                        pop_busy_i,
  input  logic                        enable_i,
  input  stream_buf_pkg::drop_t       drop_i
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  // shift register never takes a word when it has no room
  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i.valid |-> !status_i.full)
    else begin
      $error("push reached the shift register while full");
      fail_count++;
    end

  // nothing to remove from an empty buffer
  no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !status_i.empty)
    else begin
      $error("pop reached the shift register while empty");
      fail_count++;
    end

  // a second pop must not arrive while the deferred one still waits
  no_pop_stack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pop_i && push_i.valid && pop_busy_i))
    else begin
      $error("pop and push arrived with a pop still pending");
      fail_count++;
    end

  // only a disabled or full buffer rejects pushes
  push_drop_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    drop_i.push_drop |-> (!enable_i || status_i.full))
    else begin
      $error("push dropped while enabled and not full");
      fail_count++;
    end

endmodule

// the top holds both sides of the guard so one instance sees everything
bind stream_buf_top stream_buf_properties u_stream_buf_properties (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .push_i     (push_acc),
  .pop_i      (pop_acc),
  .status_i   (status),
  .pop_busy_i (pop_busy),
  .enable_i   (enable),
  .drop_i     (drops)
);

// ==== tests/stream_buf_tb.sv ====
// directed testbench; tests share one DUT in a fixed order and each leaves the buffer empty
`timescale 1ns/1ps

module stream_buf_tb;

  localparam int unsigned Seed      = 32'h00ce_932f;
  // cycles allowed for any flag to reach its expected value
  localparam int unsigned WaitLimit = 64;
  // cycles given to the front word after a push or pop
  localparam int unsigned Settle    = 3;
  localparam int          FlagEmpty = 0;
  localparam int          FlagFull  = 1;
  localparam int          FlagIrq   = 2;

  logic                                 clk_i;
  logic                                 rst_n_i;
  stream_buf_pkg::push_req_t            wr_i;
  logic                                 rd_i;
  logic [stream_buf_pkg::DataWidth-1:0] rd_data_o;
  stream_buf_pkg::cfg_req_t             cfg_i;
  logic [stream_buf_pkg::DataWidth-1:0] cfg_rdata_o;
  logic                                 empty_o;
  logic                                 full_o;
  logic                                 level_irq_o;

  // reference model of contents, drop counts and enable
  logic [stream_buf_pkg::DataWidth-1:0] model_q[$];
  int unsigned                          push_drops;
  int unsigned                          pop_drops;
  logic                                 enabled;

  stream_buf_top u_stream_buf_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_i        (wr_i),
    .rd_i        (rd_i),
    .rd_data_o   (rd_data_o),
    .cfg_i       (cfg_i),
    .cfg_rdata_o (cfg_rdata_o),
    .empty_o     (empty_o),
    .full_o      (full_o),
    .level_irq_o (level_irq_o)
  );

  // 20 ns clock
  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // a failed bound assertion ends the run at the next falling edge
  always @(negedge clk_i) begin
    if (u_stream_buf_top.u_stream_buf_properties.fail_count != 0) begin
      stop_run("a bound assertion failed");
    end
  end

  task automatic check_data(input string name, input logic [stream_buf_pkg::DataWidth-1:0] got,
                            input logic [stream_buf_pkg::DataWidth-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_level(input string name,
                             input logic [stream_buf_pkg::LengthWidth-1:0] got,
                             input logic [stream_buf_pkg::LengthWidth-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic flag_value(input int sel);
    case (sel)
      FlagEmpty: flag_value = empty_o;
      FlagFull:  flag_value = full_o;
      default:   flag_value = level_irq_o;
    endcase
  endfunction

  // every task starts and ends on a falling edge
  task automatic idle(input int unsigned cycles);
    repeat (cycles) @(negedge clk_i);
  endtask

  task automatic wait_flag(input int sel, input logic value, input string name);
    int unsigned n;
    n = 0;
    while (flag_value(sel) !== value) begin
      if (n == WaitLimit) begin
        stop_run($sformatf("timeout waiting for %s to become %0d", name, value));
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic cfg_write(input stream_buf_pkg::cfg_addr_e addr,
                           input logic [stream_buf_pkg::DataWidth-1:0] data);
    cfg_i = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
    @(negedge clk_i);
    cfg_i.valid = 1'b0;
  endtask

  // read data is registered so it is ready one cycle after the request
  task automatic cfg_read(input stream_buf_pkg::cfg_addr_e addr,
                          output logic [stream_buf_pkg::DataWidth-1:0] data);
    cfg_i = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
    @(negedge clk_i);
    cfg_i.valid = 1'b0;
    data = cfg_rdata_o;
  endtask

  // one-cycle push strobe, model follows the guard rules
  task automatic push_word(input logic [stream_buf_pkg::DataWidth-1:0] data);
    wr_i = '{valid: 1'b1, data: data};
    if (enabled && (model_q.size() < stream_buf_pkg::NumWords)) begin
      model_q.push_back(data);
    end else begin
      push_drops++;
    end
    @(negedge clk_i);
    wr_i.valid = 1'b0;
  endtask

  task automatic pop_word();
    rd_i = 1'b1;
    if (model_q.size() > 0) begin
      void'(model_q.pop_front());
    end else begin
      pop_drops++;
    end
    @(negedge clk_i);
    rd_i = 1'b0;
  endtask

  // flags, level, drop counters and front word against the model
  task automatic check_model();
    logic [stream_buf_pkg::DataWidth-1:0] value;
    idle(Settle);
    check_flag("empty_o", empty_o, model_q.size() == 0);
    check_flag("full_o", full_o, model_q.size() == stream_buf_pkg::NumWords);
    cfg_read(stream_buf_pkg::CFG_LEVEL, value);
    check_level("LEVEL", value[stream_buf_pkg::LengthWidth-1:0],
                stream_buf_pkg::LengthWidth'(model_q.size()));
    cfg_read(stream_buf_pkg::CFG_DROPS, value);
    check_data("DROPS", value, {stream_buf_pkg::CntWidth'(push_drops),
                                stream_buf_pkg::CntWidth'(pop_drops)});
    if (model_q.size() > 0) begin
      check_data("rd_data_o", rd_data_o, model_q[0]);
    end
  endtask

  task automatic drain();
    while (model_q.size() > 0) begin
      pop_word();
      check_model();
    end
    wait_flag(FlagEmpty, 1'b1, "empty_o");
  endtask

  task automatic test_reset_disable();
    logic [stream_buf_pkg::DataWidth-1:0] value;
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("full_o", full_o, 1'b0);
    check_flag("level_irq_o", level_irq_o, 1'b0);
    cfg_read(stream_buf_pkg::CFG_CTRL, value);
    check_data("CTRL", value, '0);
    cfg_read(stream_buf_pkg::CFG_WATERMARK, value);
    check_data("WATERMARK", value, '0);
    check_model();
    // disabled buffer turns every push into a drop
    repeat (3) push_word($urandom());
    check_model();
  endtask

  task automatic test_ordering();
    cfg_write(stream_buf_pkg::CFG_CTRL, 32'h1);
    enabled = 1'b1;
    for (int i = 0; i < 10; i++) begin
      push_word($urandom());
      idle($urandom_range(3, 1));
    end
    check_model();
    drain();
  endtask

  task automatic test_full_overflow();
    // back to back, the last three find the buffer full
    for (int i = 0; i < stream_buf_pkg::NumWords + 3; i++) begin
      push_word($urandom());
    end
    wait_flag(FlagFull, 1'b1, "full_o");
    check_model();
    drain();
  endtask

  task automatic test_underflow();
    for (int i = 0; i < 3; i++) begin
      pop_word();
      idle(1);
    end
    check_model();
  endtask

  task automatic test_collision();
    logic [stream_buf_pkg::DataWidth-1:0] data;
    push_word($urandom());
    push_word($urandom());
    check_model();
    data = $urandom();
    // push and pop in one cycle, level stays put
    wr_i = '{valid: 1'b1, data: data};
    rd_i = 1'b1;
    void'(model_q.pop_front());
    model_q.push_back(data);
    @(negedge clk_i);
    // rd held high meets the pending pop and is dropped
    wr_i.valid = 1'b0;
    pop_drops++;
    @(negedge clk_i);
    rd_i = 1'b0;
    check_model();
    drain();
  endtask

  task automatic test_watermark();
    logic [stream_buf_pkg::DataWidth-1:0] value;
    cfg_write(stream_buf_pkg::CFG_WATERMARK, 32'd5);
    wait_flag(FlagIrq, 1'b0, "level_irq_o");
    cfg_read(stream_buf_pkg::CFG_WATERMARK, value);
    check_data("WATERMARK", value, 32'd5);
    repeat (5) push_word($urandom());
    wait_flag(FlagIrq, 1'b1, "level_irq_o");
    pop_word();
    wait_flag(FlagIrq, 1'b0, "level_irq_o");
    check_model();
    drain();
  endtask

  initial begin
    wr_i       = '0;
    rd_i       = 1'b0;
    cfg_i      = '0;
    rst_n_i    = 1'b0;
    enabled    = 1'b0;
    push_drops = 0;
    pop_drops  = 0;
    // seed the generator once for the whole run
    void'($urandom(Seed));
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset_disable();
    test_ordering();
    test_full_overflow();
    test_underflow();
    test_collision();
    test_watermark();
    if (u_stream_buf_top.u_stream_buf_properties.fail_count != 0) begin
      stop_run("a bound assertion failed");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
source/stream_buf_pkg.sv
source/sram_sp.sv
source/sram_shift_reg.sv
source/buffer_guard.sv
source/buffer_regs.sv
source/stream_buf_top.sv
tests/stream_buf_properties.sv
tests/stream_buf_tb.sv

// ==== Bender.yml ====
package:
  name: stream_buf

sources:
  # package first, then the RTL from leaves to top
  - files:
      - source/stream_buf_pkg.sv
      - source/sram_sp.sv
      - source/sram_shift_reg.sv
      - source/buffer_guard.sv
      - source/buffer_regs.sv
      - source/stream_buf_top.sv
  - target: test
    files:
      - tests/stream_buf_properties.sv
      - tests/stream_buf_tb.sv
